// File: pkt_fifo_pkg.sv
package pkt_fifo_pkg;

   // -------------------------------------------------------------------------
   // statistics readout
   // -------------------------------------------------------------------------

   localparam int STAT_W = 32;  // counter and stat_data width

   // counter selector on the req/ack port
   typedef enum logic [1:0] {
      STAT_PKTS_OUT     = 2'd0,  // packets leaving on egress
      STAT_BYTES_OUT    = 2'd1,  // tkeep bytes leaving on egress
      STAT_PKTS_DROPPED = 2'd2,  // whole packets lost to overflow
      STAT_BEATS_IN     = 2'd3   // every ingress beat, kept or not
   } stat_sel_e;

   // -------------------------------------------------------------------------
   // ingress packet state
   // -------------------------------------------------------------------------

   typedef enum logic [1:0] {
      ING_IDLE   = 2'd0,  // between packets
      ING_ACCEPT = 2'd1,  // mid packet, beats going to storage
      ING_DROP   = 2'd2   // swallowing the tail of a lost packet
   } ingress_state_e;

endpackage

// File: pkt_fifo_mem.sv
`timescale 1ns/100ps

module pkt_fifo_mem #(
   parameter int FIFO_DEPTH    = 64,
   parameter int DATA_BYTE_WID = 4
) (
   input  logic                       axi4s_out,
   input  logic                       rst_n,

   input  logic                       wr,
   input  logic                       wr_commit,
   input  logic                       wr_abort,
   input  logic [DATA_BYTE_WID*8-1:0] wr_tdata,
   input  logic [DATA_BYTE_WID-1:0]   wr_tkeep,
   input  logic                       wr_tlast,
   output logic                       full,

   input  logic                       rd,
   output logic [DATA_BYTE_WID*8-1:0] rd_tdata,
   output logic [DATA_BYTE_WID-1:0]   rd_tkeep,
   output logic                       rd_tlast,
   output logic                       rd_empty
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);
   localparam int CNT_W = PTR_W + 1;  // extra wrap bit

   logic [DATA_BYTE_WID*8-1:0] mem_tdata [FIFO_DEPTH];
   logic [DATA_BYTE_WID-1:0]   mem_tkeep [FIFO_DEPTH];
   logic                       mem_tlast [FIFO_DEPTH];

   logic [CNT_W-1:0] wr_ptr;      // tentative write pointer
   logic [CNT_W-1:0] cmt_ptr;     // end of committed packets
   logic [CNT_W-1:0] rd_ptr;
   logic [CNT_W-1:0] wr_ptr_nxt;
   logic [CNT_W-1:0] used_cnt;
   logic [CNT_W-1:0] avail_cnt;
   logic             wr_en;
   logic             rd_en;

   // occupancy includes tentative words while readability stops at the commit point
   assign used_cnt  = wr_ptr - rd_ptr;
   assign avail_cnt = cmt_ptr - rd_ptr;
   assign full      = (used_cnt == CNT_W'(FIFO_DEPTH));
   assign rd_empty  = (avail_cnt == '0);

   assign wr_en      = wr && !full;
   assign rd_en      = rd && !rd_empty;
   assign wr_ptr_nxt = wr_ptr + CNT_W'(wr_en);

   // -------------------------------------------------------------------------
   // pointers
   // -------------------------------------------------------------------------
   always_ff @(posedge axi4s_out or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr  <= '0;
         cmt_ptr <= '0;
         rd_ptr  <= '0;
      end else begin
         if (wr_abort) begin
            wr_ptr <= cmt_ptr;  // throw away the partial packet
         end else begin
            wr_ptr <= wr_ptr_nxt;
         end
         if (wr_commit) begin
            cmt_ptr <= wr_ptr_nxt;  // includes a tlast word written this edge
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // storage array
   always_ff @(posedge axi4s_out) begin
      if (wr_en) begin
         mem_tdata[wr_ptr[PTR_W-1:0]] <= wr_tdata;
         mem_tkeep[wr_ptr[PTR_W-1:0]] <= wr_tkeep;
         mem_tlast[wr_ptr[PTR_W-1:0]] <= wr_tlast;
      end
   end

   // first word fall through
   assign rd_tdata = mem_tdata[rd_ptr[PTR_W-1:0]];
   assign rd_tkeep = mem_tkeep[rd_ptr[PTR_W-1:0]];
   assign rd_tlast = mem_tlast[rd_ptr[PTR_W-1:0]];

endmodule

// File: pkt_ingress_ctrl.sv
`timescale 1ns/100ps

module pkt_ingress_ctrl
   import pkt_fifo_pkg::*;
(
   input  logic axi4s_out,
   input  logic rst_n,

   input  logic in_tvalid,
   input  logic in_tlast,
   input  logic full,

   output logic wr,
   output logic wr_commit,
   output logic wr_abort,
   output logic pkt_drop
);

   ingress_state_e state;
   ingress_state_e state_nxt;

   always_ff @(posedge axi4s_out or negedge rst_n) begin
      if (!rst_n) begin
         state <= ING_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // -------------------------------------------------------------------------
   // per-packet accept / drop decision
   // -------------------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      wr        = 1'b0;
      wr_commit = 1'b0;
      wr_abort  = 1'b0;
      pkt_drop  = 1'b0;

      case (state)
         ING_IDLE,
         ING_ACCEPT: begin
            if (in_tvalid) begin
               if (full) begin
                  // beat lost, so the whole packet goes
                  pkt_drop  = 1'b1;
                  wr_abort  = (state == ING_ACCEPT);  // nothing tentative at packet start
                  state_nxt = in_tlast ? ING_IDLE : ING_DROP;
               end else begin
                  wr        = 1'b1;
                  wr_commit = in_tlast;  // packet becomes readable
                  state_nxt = in_tlast ? ING_IDLE : ING_ACCEPT;
               end
            end
         end

         ING_DROP: begin
            // discard through the tlast beat
            if (in_tvalid && in_tlast) begin
               state_nxt = ING_IDLE;
            end
         end

         default: begin
            state_nxt = ING_IDLE;
         end
      endcase
   end

endmodule

// File: pkt_fifo_sync.sv
`timescale 1ns/100ps

module pkt_fifo_sync #(
   parameter int FIFO_DEPTH    = 64,
   parameter int DATA_BYTE_WID = 4
) (
   input  logic                       axi4s_out,
   input  logic                       rst_n,

   input  logic [DATA_BYTE_WID*8-1:0] in_tdata,
   input  logic [DATA_BYTE_WID-1:0]   in_tkeep,
   input  logic                       in_tlast,
   input  logic                       in_tvalid,

   output logic [DATA_BYTE_WID*8-1:0] out_tdata,
   output logic [DATA_BYTE_WID-1:0]   out_tkeep,
   output logic                       out_tlast,
   output logic                       out_tvalid,
   input  logic                       out_tready,

   output logic                       oflow
);

   logic wr;
   logic wr_commit;
   logic wr_abort;
   logic full;
   logic rd;
   logic rd_empty;
   logic pkt_drop;

   // ingress side ignores back-pressure
   pkt_ingress_ctrl u_ingress (
      .axi4s_out (axi4s_out),
      .rst_n     (rst_n),
      .in_tvalid (in_tvalid),
      .in_tlast  (in_tlast),
      .full      (full),
      .wr        (wr),
      .wr_commit (wr_commit),
      .wr_abort  (wr_abort),
      .pkt_drop  (pkt_drop)
   );

   pkt_fifo_mem #(
      .FIFO_DEPTH    (FIFO_DEPTH),
      .DATA_BYTE_WID (DATA_BYTE_WID)
   ) u_mem (
      .axi4s_out (axi4s_out),
      .rst_n     (rst_n),
      .wr        (wr),
      .wr_commit (wr_commit),
      .wr_abort  (wr_abort),
      .wr_tdata  (in_tdata),
      .wr_tkeep  (in_tkeep),
      .wr_tlast  (in_tlast),
      .full      (full),
      .rd        (rd),
      .rd_tdata  (out_tdata),
      .rd_tkeep  (out_tkeep),
      .rd_tlast  (out_tlast),
      .rd_empty  (rd_empty)
   );

   // egress only sees committed packets, so store-and-forward comes for free
   assign out_tvalid = !rd_empty;
   assign rd         = out_tvalid && out_tready;  // pop on transfer

   assign oflow = pkt_drop;

endmodule

// File: stream_probe.sv
`timescale 1ns/100ps

module stream_probe
   import pkt_fifo_pkg::*;
#(
   parameter int DATA_BYTE_WID = 4
) (
   input  logic                     axi4s_out,
   input  logic                     rst_n,

   input  logic                     in_tvalid,
   input  logic                     out_tvalid,
   input  logic                     out_tready,
   input  logic                     out_tlast,
   input  logic [DATA_BYTE_WID-1:0] out_tkeep,
   input  logic                     pkt_drop,

   input  logic                     stat_req,
   input  stat_sel_e                stat_sel,
   output logic                     stat_ack,
   output logic [STAT_W-1:0]        stat_data
);

   localparam int KEEP_CNT_W = $clog2(DATA_BYTE_WID + 1);

   logic [STAT_W-1:0]     pkts_out_cnt;
   logic [STAT_W-1:0]     bytes_out_cnt;
   logic [STAT_W-1:0]     pkts_drop_cnt;
   logic [STAT_W-1:0]     beats_in_cnt;
   logic [STAT_W-1:0]     sel_cnt;
   logic [KEEP_CNT_W-1:0] keep_ones;
   logic                  out_xfer;

   assign out_xfer = out_tvalid && out_tready;

   // bytes in this beat
   always_comb begin
      keep_ones = '0;
      for (int i = 0; i < DATA_BYTE_WID; i++) begin
         keep_ones = keep_ones + KEEP_CNT_W'(out_tkeep[i]);
      end
   end

   // -------------------------------------------------------------------------
   // wrapping counters
   // -------------------------------------------------------------------------
   always_ff @(posedge axi4s_out or negedge rst_n) begin
      if (!rst_n) begin
         pkts_out_cnt  <= '0;
         bytes_out_cnt <= '0;
         pkts_drop_cnt <= '0;
         beats_in_cnt  <= '0;
      end else begin
         if (in_tvalid) begin
            beats_in_cnt <= beats_in_cnt + 1'b1;  // kept or dropped
         end
         if (out_xfer) begin
            bytes_out_cnt <= bytes_out_cnt + STAT_W'(keep_ones);
         end
         if (out_xfer && out_tlast) begin
            pkts_out_cnt <= pkts_out_cnt + 1'b1;
         end
         if (pkt_drop) begin
            pkts_drop_cnt <= pkts_drop_cnt + 1'b1;
         end
      end
   end

   always_comb begin
      case (stat_sel)
         STAT_PKTS_OUT:     sel_cnt = pkts_out_cnt;
         STAT_BYTES_OUT:    sel_cnt = bytes_out_cnt;
         STAT_PKTS_DROPPED: sel_cnt = pkts_drop_cnt;
         STAT_BEATS_IN:     sel_cnt = beats_in_cnt;
         default:           sel_cnt = '0;
      endcase
   end

   // -------------------------------------------------------------------------
   // four-phase readout
   // -------------------------------------------------------------------------
   always_ff @(posedge axi4s_out or negedge rst_n) begin
      if (!rst_n) begin
         stat_ack  <= 1'b0;
         stat_data <= '0;
      end else if (stat_req && !stat_ack) begin
         stat_data <= sel_cnt;  // snapshot held until next request
         stat_ack  <= 1'b1;
      end else if (!stat_req && stat_ack) begin
         stat_ack  <= 1'b0;
      end
   end

endmodule

// File: pkt_fifo_top.sv
`timescale 1ns/100ps

module pkt_fifo_top
   import pkt_fifo_pkg::*;
#(
   parameter int FIFO_DEPTH    = 64,  // power of two
   parameter int DATA_BYTE_WID = 4
) (
   input  logic                       axi4s_out,
   input  logic                       rst_n,

   input  logic [DATA_BYTE_WID*8-1:0] in_tdata,
   input  logic [DATA_BYTE_WID-1:0]   in_tkeep,
   input  logic                       in_tlast,
   input  logic                       in_tvalid,

   output logic [DATA_BYTE_WID*8-1:0] out_tdata,
   output logic [DATA_BYTE_WID-1:0]   out_tkeep,
   output logic                       out_tlast,
   output logic                       out_tvalid,
   input  logic                       out_tready,

   output logic                       oflow,

   input  logic                       stat_req,
   input  stat_sel_e                  stat_sel,
   output logic                       stat_ack,
   output logic [STAT_W-1:0]          stat_data
);

   pkt_fifo_sync #(
      .FIFO_DEPTH    (FIFO_DEPTH),
      .DATA_BYTE_WID (DATA_BYTE_WID)
   ) u_fifo (
      .axi4s_out  (axi4s_out),
      .rst_n      (rst_n),
      .in_tdata   (in_tdata),
      .in_tkeep   (in_tkeep),
      .in_tlast   (in_tlast),
      .in_tvalid  (in_tvalid),
      .out_tdata  (out_tdata),
      .out_tkeep  (out_tkeep),
      .out_tlast  (out_tlast),
      .out_tvalid (out_tvalid),
      .out_tready (out_tready),
      .oflow      (oflow)
   );

   // probe only listens to both sides
   stream_probe #(
      .DATA_BYTE_WID (DATA_BYTE_WID)
   ) u_probe (
      .axi4s_out  (axi4s_out),
      .rst_n      (rst_n),
      .in_tvalid  (in_tvalid),
      .out_tvalid (out_tvalid),
      .out_tready (out_tready),
      .out_tlast  (out_tlast),
      .out_tkeep  (out_tkeep),
      .pkt_drop   (oflow),
      .stat_req   (stat_req),
      .stat_sel   (stat_sel),
      .stat_ack   (stat_ack),
      .stat_data  (stat_data)
   );

endmodule

// File: tb_pkt_fifo_top.sv
`timescale 1ns/100ps

module tb_pkt_fifo_top
   import pkt_fifo_pkg::*;
();

   localparam int DEPTH = 64;

   logic        axi4s_out;
   logic        rst_n;
   logic [31:0] in_tdata;
   logic [3:0]  in_tkeep;
   logic        in_tlast;
   logic        in_tvalid;
   logic [31:0] out_tdata;
   logic [3:0]  out_tkeep;
   logic        out_tlast;
   logic        out_tvalid;
   logic        out_tready;
   logic        oflow;
   logic        stat_req;
   stat_sel_e   stat_sel;
   logic        stat_ack;
   logic [31:0] stat_data;

   // reference model
   logic [31:0] exp_data [$];
   logic [3:0]  exp_keep [$];
   logic        exp_last [$];
   int          sent_pkts;     // kept packets whose tlast went in
   int          rcvd_pkts;
   int          oflow_cnt;
   int          beats_in_m;
   int          bytes_out_m;
   int          drops_m;
   int          stored;        // committed words while egress is stalled
   int          val_errs;
   int          proto_errs;
   int          tmo_errs;
   logic        ready_rand;
   string       test_name;
   logic [31:0] rng      = 32'hda8b4fb8;
   logic [31:0] rdy_rng  = 32'hda8b4fb8;

   pkt_fifo_top #(.FIFO_DEPTH(DEPTH), .DATA_BYTE_WID(4)) uut (.*);

   initial begin
      axi4s_out = 1'b0;
      forever #4 axi4s_out = ~axi4s_out;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int draw_len(input int lo, input int hi);
      rng = xorshift32(rng);
      return lo + int'(rng % (hi - lo + 1));
   endfunction

   task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
      assert (exp == act) else begin
         val_errs++;
         $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      end
   endtask

   // ------------------------------------------------------------------------
   // egress stall pattern
   // ------------------------------------------------------------------------
   always @(negedge axi4s_out) begin
      rdy_rng = xorshift32(rdy_rng);
      out_tready = ready_rand && rdy_rng[0];
   end

   // scoreboard on the egress side
   always @(posedge axi4s_out) begin
      if (rst_n) begin
         if (oflow) oflow_cnt++;
         assert (!out_tvalid || sent_pkts > rcvd_pkts) else begin
            proto_errs++;
            $display("%s: out_tvalid rose before a whole packet was accepted", test_name);
         end
         if (out_tvalid && out_tready) begin
            if (exp_data.size() == 0) begin
               val_errs++;
               $display("%s: egress beat seen while no beat was expected", test_name);
            end else begin
               check_val("egress tdata", exp_data[0], out_tdata);
               check_val("egress tkeep", exp_keep[0], out_tkeep);
               check_val("egress tlast", exp_last[0], out_tlast);
               exp_data.delete(0);
               exp_keep.delete(0);
               exp_last.delete(0);
               if (out_tlast) rcvd_pkts++;
            end
         end
      end
   end

   a_hold: assert property (@(posedge axi4s_out) disable iff (!rst_n)
      out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata) &&
      $stable(out_tkeep) && $stable(out_tlast))
      else begin
         proto_errs++;
         $display("egress beat changed or vanished while out_tready was low");
      end

   a_ack_rise: assert property (@(posedge axi4s_out) disable iff (!rst_n)
      $rose(stat_ack) |-> $past(stat_req))
      else begin
         proto_errs++;
         $display("stat_ack rose without a pending stat_req");
      end

   a_ack_fall: assert property (@(posedge axi4s_out) disable iff (!rst_n)
      $fell(stat_ack) |-> !$past(stat_req))
      else begin
         proto_errs++;
         $display("stat_ack fell while stat_req was still high");
      end

   // sends one packet on consecutive cycles and idles one cycle after it
   task automatic send_pkt(input int len, input logic keep_it);
      for (int i = 0; i < len; i++) begin
         @(negedge axi4s_out);
         rng = xorshift32(rng);
         in_tdata = rng;
         rng = xorshift32(rng);
         in_tkeep  = rng[3:0];
         in_tlast  = (i == len - 1);
         in_tvalid = 1'b1;
         if (keep_it) begin
            exp_data.push_back(in_tdata);
            exp_keep.push_back(in_tkeep);
            exp_last.push_back(in_tlast);
            bytes_out_m += $countones(in_tkeep);
         end
      end
      @(negedge axi4s_out);
      in_tvalid = 1'b0;
      in_tlast  = 1'b0;
      beats_in_m += len;
      if (keep_it) sent_pkts++;
      else drops_m++;
   endtask

   task automatic wait_drain();
      int t;
      t = 0;
      while ((exp_data.size() != 0 || out_tvalid) && t < 4000) begin
         @(negedge axi4s_out);
         t++;
      end
      if (exp_data.size() != 0 || out_tvalid) begin
         tmo_errs++;
         $display("%s: egress never drained, %0d beats missing", test_name, exp_data.size());
      end
   endtask

   task automatic read_stat(input stat_sel_e sel, input logic [31:0] exp, input string what);
      int t;
      @(negedge axi4s_out);
      stat_sel = sel;
      stat_req = 1'b1;
      t = 0;
      while (!stat_ack && t < 20) begin
         @(negedge axi4s_out);
         t++;
      end
      if (!stat_ack) begin
         tmo_errs++;
         $display("%s: no stat_ack for the %s read", test_name, what);
      end else begin
         check_val(what, exp, stat_data);
      end
      stat_req = 1'b0;
      t = 0;
      while (stat_ack && t < 20) begin
         @(negedge axi4s_out);
         t++;
      end
      if (stat_ack) begin
         tmo_errs++;
         $display("%s: stat_ack stuck high after the %s read", test_name, what);
      end
   endtask

   task automatic read_all();
      read_stat(STAT_PKTS_OUT, sent_pkts, "pkts_out");
      read_stat(STAT_BYTES_OUT, bytes_out_m, "bytes_out");
      read_stat(STAT_PKTS_DROPPED, drops_m, "pkts_dropped");
      read_stat(STAT_BEATS_IN, beats_in_m, "beats_in");
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial begin
      int   len;
      logic keep;
      rst_n = 1'b0;
      in_tdata = '0;
      in_tkeep = '0;
      in_tlast = 1'b0;
      in_tvalid = 1'b0;
      out_tready = 1'b0;
      ready_rand = 1'b0;
      stat_req = 1'b0;
      stat_sel = STAT_PKTS_OUT;
      {sent_pkts, rcvd_pkts, oflow_cnt, beats_in_m, bytes_out_m, drops_m} = '0;
      {val_errs, proto_errs, tmo_errs, stored} = '0;
      test_name = "reset";
      repeat (8) @(negedge axi4s_out);
      rst_n = 1'b1;
      @(negedge axi4s_out);
      check_val("out_tvalid", 0, out_tvalid);
      check_val("oflow", 0, oflow);
      check_val("stat_ack", 0, stat_ack);
      read_all();

      test_name = "order";  // never more than DEPTH words in flight
      ready_rand = 1'b1;
      for (int n = 0; n < 40; n++) begin
         len = draw_len(1, 12);
         if (exp_data.size() + len > DEPTH) wait_drain();
         send_pkt(len, 1'b1);
      end
      wait_drain();
      check_val("oflow count", drops_m, oflow_cnt);

      test_name = "drop";
      ready_rand = 1'b0;
      stored = 0;
      for (int n = 0; n < 10; n++) begin
         len  = draw_len(4, 19);
         keep = (stored + len <= DEPTH);
         send_pkt(len, keep);
         if (keep) stored += len;
         check_val("oflow count", drops_m, oflow_cnt);
      end
      if (stored < DEPTH) begin
         send_pkt(DEPTH - stored, 1'b1);  // top up to exactly full
         stored = DEPTH;
      end
      send_pkt(1, 1'b0);  // single beat into a full FIFO
      check_val("oflow count", drops_m, oflow_cnt);
      ready_rand = 1'b1;
      wait_drain();

      test_name = "recovery";
      for (int n = 0; n < 20; n++) begin
         len = draw_len(1, 12);
         if (exp_data.size() + len > DEPTH) wait_drain();
         send_pkt(len, 1'b1);
      end
      wait_drain();
      check_val("oflow count", drops_m, oflow_cnt);

      test_name = "counters";
      read_all();

      $display("errors: %0d value, %0d protocol, %0d timeout", val_errs, proto_errs, tmo_errs);
      if (val_errs + proto_errs + tmo_errs == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// File: pkt_fifo_top.f
pkt_fifo_pkg.sv
pkt_fifo_mem.sv
pkt_ingress_ctrl.sv
pkt_fifo_sync.sv
stream_probe.sv
pkt_fifo_top.sv
tb_pkt_fifo_top.sv
